/* rtl/core_macros.svh */
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath and address width.
`define ISA_WIDTH 32

// architectural registers, x0 included.
`define GPR_COUNT 32

// one enable per byte lane of the data port.
`define MEM_MASK_WIDTH 4

// first fetch address after reset.
`define RESET_PC 32'h8000_0000

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* rtl/core_pkg.sv */
`default_nettype none

package core_pkg;

    // immediate format of the current instruction.
    typedef enum logic [2:0] {
        inst_r = 3'd0,
        inst_i = 3'd1,
        inst_s = 3'd2,
        inst_b = 3'd3,
        inst_u = 3'd4,
        inst_j = 3'd5
    } inst_type_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_funct_t;

    typedef enum logic [1:0] {
        dnpc_snpc   = 2'd0, // pc + 4.
        dnpc_pc_imm = 2'd1, // jal and taken branches.
        dnpc_jalr   = 2'd2
    } dnpc_sel_t;

    typedef enum logic [2:0] {
        srd_alu    = 3'd0,
        srd_mem    = 3'd1,
        srd_snpc   = 3'd2, // link address.
        srd_pc_imm = 3'd3,
        srd_imm    = 3'd4
    } srd_sel_t;

endpackage

`default_nettype wire

/* rtl/core_ifu.sv */
`default_nettype none
`include "core_macros.svh"

module core_ifu import core_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  dnpc_sel_t             dnpc_sel,
    input  logic [`ISA_WIDTH-1:0] pc_imm,
    input  logic [`ISA_WIDTH-1:0] alu_result,
    output logic [`ISA_WIDTH-1:0] pc,
    output logic [`ISA_WIDTH-1:0] snpc,
    output logic [`ISA_WIDTH-1:0] inst,
    input  logic [`ISA_WIDTH-1:0] mem_1_r,
    output logic [`ISA_WIDTH-1:0] mem_1_addr,
    output logic                  mem_1_r_en
);

    logic [`ISA_WIDTH-1:0] dnpc;

    assign snpc = pc + `ISA_WIDTH'd4;

    always_comb begin
        case (dnpc_sel)
            dnpc_pc_imm: dnpc = pc_imm;
            dnpc_jalr:   dnpc = {alu_result[`ISA_WIDTH-1:1], 1'b0}; // target bit 0 dropped.
            default:     dnpc = snpc;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else begin
            pc <= dnpc;
        end
    end

    assign mem_1_addr = pc;
    assign mem_1_r_en = !reset;
    assign inst       = reset ? `NOP_INST : mem_1_r; // keeps writes quiet in reset.

endmodule

`default_nettype wire

/* rtl/core_idu.sv */
`default_nettype none
`include "core_macros.svh"

module core_idu import core_pkg::*; (
    input  logic                  clk,
    input  logic [`ISA_WIDTH-1:0] inst,
    input  inst_type_t            inst_type,
    input  logic [`ISA_WIDTH-1:0] srd,
    input  logic                  gpr_w_en,
    output logic [`ISA_WIDTH-1:0] imm,
    output logic [`ISA_WIDTH-1:0] src1,
    output logic [`ISA_WIDTH-1:0] src2,
    output logic [6:0]            opcode,
    output logic [2:0]            funct3,
    output logic [6:0]            funct7
);

    localparam int REG_IDX_WIDTH = $clog2(`GPR_COUNT);

    logic [REG_IDX_WIDTH-1:0] rs1;
    logic [REG_IDX_WIDTH-1:0] rs2;
    logic [REG_IDX_WIDTH-1:0] rd;

    // x0 has no storage.
    logic [`ISA_WIDTH-1:0] gpr [1:`GPR_COUNT-1];

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign funct7 = inst[31:25];

    always_comb begin
        case (inst_type)
            inst_i: begin
                imm = {{20{inst[31]}}, inst[31:20]};
            end
            inst_s: begin
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            end
            inst_b: begin
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            inst_u: begin
                imm = {inst[31:12], 12'b0};
            end
            inst_j: begin
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default: begin
                imm = '0; // r-type carries no immediate.
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (gpr_w_en && rd != '0) begin
            gpr[rd] <= srd;
        end
    end

    // reads see the old value when the same register is written this cycle.
    assign src1 = (rs1 == '0) ? '0 : gpr[rs1];
    assign src2 = (rs2 == '0) ? '0 : gpr[rs2];

endmodule

`default_nettype wire

/* rtl/core_ctrl.sv */
`default_nettype none

module core_ctrl import core_pkg::*; (
    input  logic [6:0] opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  logic       branch_taken,
    output inst_type_t inst_type,
    output logic       gpr_w_en,
    output logic       alu_b_is_imm,
    output alu_funct_t alu_funct,
    output dnpc_sel_t  dnpc_sel,
    output srd_sel_t   srd_sel,
    output logic       mem_r_en,
    output logic       mem_w_en
);

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    logic alt_funct7; // selects sub and sra.

    assign alt_funct7 = (funct7 == 7'b0100000);

    function automatic alu_funct_t decode_alu(input logic [2:0] f3, input logic alt_sub);
        case (f3)
            3'b000:  return alt_sub ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt_funct7 ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    always_comb begin
        inst_type    = inst_i; // defaults give a nop.
        gpr_w_en     = 1'b0;
        alu_b_is_imm = 1'b1;
        alu_funct    = alu_add;
        dnpc_sel     = dnpc_snpc;
        srd_sel      = srd_alu;
        mem_r_en     = 1'b0;
        mem_w_en     = 1'b0;

        case (opcode)
            OP_LUI: begin
                inst_type = inst_u;
                gpr_w_en  = 1'b1;
                srd_sel   = srd_imm;
            end
            OP_AUIPC: begin
                inst_type = inst_u;
                gpr_w_en  = 1'b1;
                srd_sel   = srd_pc_imm;
            end
            OP_JAL: begin
                inst_type = inst_j;
                gpr_w_en  = 1'b1;
                srd_sel   = srd_snpc;
                dnpc_sel  = dnpc_pc_imm;
            end
            OP_JALR: begin
                gpr_w_en = 1'b1;
                srd_sel  = srd_snpc;
                dnpc_sel = dnpc_jalr; // rs1 + imm from the alu.
            end
            OP_BRANCH: begin
                inst_type    = inst_b;
                alu_b_is_imm = 1'b0;
                dnpc_sel     = branch_taken ? dnpc_pc_imm : dnpc_snpc;
            end
            OP_LOAD: begin
                gpr_w_en = 1'b1;
                mem_r_en = 1'b1;
                srd_sel  = srd_mem;
            end
            OP_STORE: begin
                inst_type = inst_s;
                mem_w_en  = 1'b1;
            end
            OP_IMM: begin
                gpr_w_en  = 1'b1;
                alu_funct = decode_alu(funct3, 1'b0); // no subi.
            end
            OP_REG: begin
                inst_type    = inst_r;
                gpr_w_en     = 1'b1;
                alu_b_is_imm = 1'b0;
                alu_funct    = decode_alu(funct3, alt_funct7);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/core_exu.sv */
`default_nettype none
`include "core_macros.svh"

module core_exu import core_pkg::*; (
    input  logic [`ISA_WIDTH-1:0] pc,
    input  logic [`ISA_WIDTH-1:0] src1,
    input  logic [`ISA_WIDTH-1:0] src2,
    input  logic [`ISA_WIDTH-1:0] imm,
    input  logic                  alu_b_is_imm,
    input  alu_funct_t            alu_funct,
    input  logic [2:0]            funct3,
    output logic [`ISA_WIDTH-1:0] alu_result,
    output logic [`ISA_WIDTH-1:0] pc_imm,
    output logic                  branch_taken
);

    logic [`ISA_WIDTH-1:0] alu_b;
    logic [4:0]            shamt;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign alu_b       = alu_b_is_imm ? imm : src2;
    assign shamt       = alu_b[4:0];
    assign lt_signed   = $signed(src1) < $signed(alu_b);
    assign lt_unsigned = src1 < alu_b;

    always_comb begin
        case (alu_funct)
            alu_sub:  alu_result = src1 - alu_b;
            alu_sll:  alu_result = src1 << shamt;
            alu_slt:  alu_result = {{(`ISA_WIDTH-1){1'b0}}, lt_signed};
            alu_sltu: alu_result = {{(`ISA_WIDTH-1){1'b0}}, lt_unsigned};
            alu_xor:  alu_result = src1 ^ alu_b;
            alu_srl:  alu_result = src1 >> shamt;
            alu_sra:  alu_result = $signed(src1) >>> shamt;
            alu_or:   alu_result = src1 | alu_b;
            alu_and:  alu_result = src1 & alu_b;
            default:  alu_result = src1 + alu_b;
        endcase
    end

    assign pc_imm = pc + imm;

    // compared on src2 directly so the alu operand choice does not matter.
    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (src1 == src2);
            3'b001:  branch_taken = (src1 != src2);
            3'b100:  branch_taken = $signed(src1) < $signed(src2);
            3'b101:  branch_taken = $signed(src1) >= $signed(src2);
            3'b110:  branch_taken = src1 < src2;
            3'b111:  branch_taken = src1 >= src2;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/core_memwb.sv */
`default_nettype none
`include "core_macros.svh"

module core_memwb import core_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [2:0]                funct3,
    input  logic [`ISA_WIDTH-1:0]     alu_result,
    input  logic [`ISA_WIDTH-1:0]     src2,
    input  logic [`ISA_WIDTH-1:0]     imm,
    input  logic [`ISA_WIDTH-1:0]     snpc,
    input  logic [`ISA_WIDTH-1:0]     pc_imm,
    input  logic                      mem_r_en,
    input  logic                      mem_w_en,
    input  srd_sel_t                  srd_sel,
    input  logic [`ISA_WIDTH-1:0]     mem_2_r,
    output logic [`ISA_WIDTH-1:0]     mem_2_w,
    output logic [`ISA_WIDTH-1:0]     mem_2_addr,
    output logic [`MEM_MASK_WIDTH-1:0] mem_2_mask,
    output logic                      mem_2_r_en,
    output logic                      mem_2_w_en,
    output logic [`ISA_WIDTH-1:0]     srd
);

    logic [1:0]                 byte_off;
    logic [4:0]                 bit_off;
    logic [`MEM_MASK_WIDTH-1:0] size_mask;
    logic [`ISA_WIDTH-1:0]      lane;
    logic [`ISA_WIDTH-1:0]      load_data;

    assign byte_off = alu_result[1:0];
    assign bit_off  = {byte_off, 3'b000};

    assign mem_2_addr = {alu_result[`ISA_WIDTH-1:2], 2'b00};
    assign mem_2_r_en = mem_r_en;
    assign mem_2_w_en = mem_w_en;

    always_comb begin
        case (funct3[1:0])
            2'b00:   size_mask = 4'b0001;
            2'b01:   size_mask = 4'b0011;
            default: size_mask = 4'b1111;
        endcase
    end

    assign mem_2_mask = size_mask << byte_off;
    assign mem_2_w    = src2 << bit_off; // move the low bytes into the addressed lanes.

    assign lane = mem_2_r >> bit_off;

    always_comb begin
        case (funct3)
            3'b000:  load_data = {{24{lane[7]}}, lane[7:0]};
            3'b001:  load_data = {{16{lane[15]}}, lane[15:0]};
            3'b100:  load_data = {24'b0, lane[7:0]};
            3'b101:  load_data = {16'b0, lane[15:0]};
            default: load_data = lane;
        endcase
    end

    always_comb begin
        case (srd_sel)
            srd_mem:    srd = load_data;
            srd_snpc:   srd = snpc;
            srd_pc_imm: srd = pc_imm;
            srd_imm:    srd = imm;
            default:    srd = alu_result;
        endcase
    end

    // the enables come from ctrl and the address from the alu.
    a_half_aligned: assert property (
        @(posedge clk) disable iff (reset)
        ((mem_r_en || mem_w_en) && funct3[1:0] == 2'b01) |-> (alu_result[0] == 1'b0)
    ) else $error("misaligned halfword access at address %h", alu_result);

    a_word_aligned: assert property (
        @(posedge clk) disable iff (reset)
        ((mem_r_en || mem_w_en) && funct3[1:0] == 2'b10) |-> (alu_result[1:0] == 2'b00)
    ) else $error("misaligned word access at address %h", alu_result);

endmodule

`default_nettype wire

/* rtl/core.sv */
`default_nettype none
`include "core_macros.svh"

module core import core_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`ISA_WIDTH-1:0]      mem_1_r,
    output logic [`ISA_WIDTH-1:0]      mem_1_addr,
    output logic                       mem_1_r_en,
    input  logic [`ISA_WIDTH-1:0]      mem_2_r,
    output logic [`ISA_WIDTH-1:0]      mem_2_w,
    output logic [`ISA_WIDTH-1:0]      mem_2_addr,
    output logic [`MEM_MASK_WIDTH-1:0] mem_2_mask,
    output logic                       mem_2_r_en,
    output logic                       mem_2_w_en
);

    logic [`ISA_WIDTH-1:0] pc;
    logic [`ISA_WIDTH-1:0] snpc;
    logic [`ISA_WIDTH-1:0] inst;
    logic [`ISA_WIDTH-1:0] imm;
    logic [`ISA_WIDTH-1:0] src1;
    logic [`ISA_WIDTH-1:0] src2;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    inst_type_t            inst_type;
    logic                  gpr_w_en;
    logic                  alu_b_is_imm;
    alu_funct_t            alu_funct;
    dnpc_sel_t             dnpc_sel;
    srd_sel_t              srd_sel;
    logic                  mem_r_en;
    logic                  mem_w_en;
    logic [`ISA_WIDTH-1:0] alu_result;
    logic [`ISA_WIDTH-1:0] pc_imm;
    logic                  branch_taken;
    logic [`ISA_WIDTH-1:0] srd;

    core_ifu ifu (
        .clk(clk), .reset(reset),
        .dnpc_sel(dnpc_sel), .pc_imm(pc_imm), .alu_result(alu_result),
        .pc(pc), .snpc(snpc), .inst(inst),
        .mem_1_r(mem_1_r), .mem_1_addr(mem_1_addr), .mem_1_r_en(mem_1_r_en)
    );

    core_idu idu (
        .clk(clk), .inst(inst), .inst_type(inst_type), .srd(srd), .gpr_w_en(gpr_w_en),
        .imm(imm), .src1(src1), .src2(src2),
        .opcode(opcode), .funct3(funct3), .funct7(funct7)
    );

    core_ctrl ctrl (
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .branch_taken(branch_taken),
        .inst_type(inst_type), .gpr_w_en(gpr_w_en), .alu_b_is_imm(alu_b_is_imm),
        .alu_funct(alu_funct), .dnpc_sel(dnpc_sel), .srd_sel(srd_sel),
        .mem_r_en(mem_r_en), .mem_w_en(mem_w_en)
    );

    core_exu exu (
        .pc(pc), .src1(src1), .src2(src2), .imm(imm),
        .alu_b_is_imm(alu_b_is_imm), .alu_funct(alu_funct), .funct3(funct3),
        .alu_result(alu_result), .pc_imm(pc_imm), .branch_taken(branch_taken)
    );

    core_memwb memwb (
        .clk(clk), .reset(reset), .funct3(funct3),
        .alu_result(alu_result), .src2(src2), .imm(imm), .snpc(snpc), .pc_imm(pc_imm),
        .mem_r_en(mem_r_en), .mem_w_en(mem_w_en), .srd_sel(srd_sel),
        .mem_2_r(mem_2_r), .mem_2_w(mem_2_w), .mem_2_addr(mem_2_addr),
        .mem_2_mask(mem_2_mask), .mem_2_r_en(mem_2_r_en), .mem_2_w_en(mem_2_w_en),
        .srd(srd)
    );

endmodule

`default_nettype wire

/* tb/core_tb_mem.sv */
`default_nettype none
`include "core_macros.svh"

module core_tb_mem (
    input  logic                       clk,
    input  logic [`ISA_WIDTH-1:0]      mem_1_addr,
    output logic [`ISA_WIDTH-1:0]      mem_1_r,
    input  logic [`ISA_WIDTH-1:0]      mem_2_addr,
    input  logic [`ISA_WIDTH-1:0]      mem_2_w,
    input  logic [`MEM_MASK_WIDTH-1:0] mem_2_mask,
    input  logic                       mem_2_w_en,
    output logic [`ISA_WIDTH-1:0]      mem_2_r
);

    timeunit 1ns;
    timeprecision 1ps;

    // 4 KiB window starting at the reset address, data lives in the upper half.
    logic [`ISA_WIDTH-1:0] words [0:1023];

    initial begin
        for (int i = 0; i < 1024; i++) begin
            words[i] = (`RESET_PC + 4 * i) * 32'h9e37_79b9; // depends on the full address.
        end
    end

    assign mem_1_r = words[mem_1_addr[11:2]];
    assign mem_2_r = words[mem_2_addr[11:2]];

    always @(posedge clk) begin
        if (mem_2_w_en) begin
            for (int b = 0; b < `MEM_MASK_WIDTH; b++) begin
                if (mem_2_mask[b]) begin
                    words[mem_2_addr[11:2]][8*b +: 8] <= mem_2_w[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb/core_tb.sv */
`default_nettype none
`include "core_macros.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] DATA_BASE = 32'h8000_0800;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic [31:0] mem_1_r, mem_1_addr, mem_2_r, mem_2_w, mem_2_addr;
    logic [3:0]  mem_2_mask;
    logic        mem_1_r_en, mem_2_r_en, mem_2_w_en;

    logic [31:0] exp_f [0:511];
    logic [31:0] exp_wa [0:255];
    logic [31:0] exp_wd [0:255];
    logic [3:0]  exp_wm [0:255];
    int          f_cnt = 0, f_idx = 0, w_cnt = 0, w_idx = 0;
    int          r_cnt = 0, r_idx = 0;
    int          errors = 0, passed = 0, failed = 0;
    logic [31:0] cur_pc;
    logic [31:0] rng_state = 32'hee59;
    string       test_name = "reset";

    core dut (
        .clk(clk), .reset(reset),
        .mem_1_r(mem_1_r), .mem_1_addr(mem_1_addr), .mem_1_r_en(mem_1_r_en),
        .mem_2_r(mem_2_r), .mem_2_w(mem_2_w), .mem_2_addr(mem_2_addr),
        .mem_2_mask(mem_2_mask), .mem_2_r_en(mem_2_r_en), .mem_2_w_en(mem_2_w_en)
    );

    core_tb_mem mem (
        .clk(clk), .mem_1_addr(mem_1_addr), .mem_1_r(mem_1_r),
        .mem_2_addr(mem_2_addr), .mem_2_w(mem_2_w), .mem_2_mask(mem_2_mask),
        .mem_2_w_en(mem_2_w_en), .mem_2_r(mem_2_r)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            f_idx <= 0;
            w_idx <= 0;
            r_idx <= 0;
        end else begin
            f_idx <= f_idx + 1;
            if (mem_2_w_en) w_idx <= w_idx + 1;
            if (mem_2_r_en) r_idx <= r_idx + 1;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic logic [31:0] enc_r(logic [6:0] f7, int rs2, int rs1, int f3, int rd);
        return {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] enc_i(logic [11:0] imm, int rs1, int f3, int rd,
                                          logic [6:0] op);
        return {imm, rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_s(logic [11:0] imm, int rs2, int rs1, int f3);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] enc_b(logic [12:0] imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] enc_u(logic [19:0] imm, int rd, logic [6:0] op);
        return {imm, rd[4:0], op};
    endfunction

    function automatic logic [31:0] enc_j(logic [20:0] imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
    endfunction

    // rv32i results, straight from the spec.
    function automatic logic [31:0] alu_model(int f3, bit alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return {31'b0, $signed(a) < $signed(b)};
            3: return {31'b0, a < b};
            4: return a ^ b;
            5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_model(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic logic [31:0] load_model(int f3, logic [31:0] w, int off);
        logic [31:0] lane;
        lane = w >> (8 * off);
        case (f3)
            0: return {{24{lane[7]}}, lane[7:0]};
            1: return {{16{lane[15]}}, lane[15:0]};
            4: return {24'b0, lane[7:0]};
            5: return {16'b0, lane[15:0]};
            default: return lane;
        endcase
    endfunction

    function automatic logic [31:0] fetch_expect(int idx);
        return (idx < f_cnt) ? exp_f[idx] : exp_f[f_cnt-1]; // closing jump repeats.
    endfunction

    function automatic bit write_matches(int i, logic [31:0] a, logic [3:0] m, logic [31:0] d);
        logic [31:0] bm;
        bm = {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
        return a == exp_wa[i] && m == exp_wm[i] && (d & bm) == (exp_wd[i] & bm);
    endfunction

    a_reset_quiet: assert property (
        @(posedge clk) reset |-> (!mem_1_r_en && !mem_2_r_en && !mem_2_w_en)
    ) else begin
        $display("%s: a memory enable was high while reset was asserted", test_name);
        errors++;
    end

    a_fetch_enable: assert property (
        @(posedge clk) !reset |-> mem_1_r_en
    ) else begin
        $display("%s: the fetch enable was low outside reset", test_name);
        errors++;
    end

    a_fetch: assert property (
        @(posedge clk) !reset |-> (mem_1_addr == fetch_expect(f_idx))
    ) else begin
        $display("mismatch %s: fetch expected %h actual %h", test_name,
                 fetch_expect($sampled(f_idx)), $sampled(mem_1_addr));
        errors++;
    end

    a_write_expected: assert property (
        @(posedge clk) (!reset && mem_2_w_en) |-> (w_idx < w_cnt)
    ) else begin
        $display("%s: unexpected data write at %h", test_name, $sampled(mem_2_addr));
        errors++;
    end

    a_write_value: assert property (
        @(posedge clk) (!reset && mem_2_w_en && w_idx < w_cnt)
            |-> write_matches(w_idx, mem_2_addr, mem_2_mask, mem_2_w)
    ) else begin
        $display("mismatch %s: expected %h/%h/%h actual %h/%h/%h (addr/mask/data)",
                 test_name, exp_wa[$sampled(w_idx)], exp_wm[$sampled(w_idx)],
                 exp_wd[$sampled(w_idx)], $sampled(mem_2_addr), $sampled(mem_2_mask),
                 $sampled(mem_2_w));
        errors++;
    end

    task automatic place(input logic [31:0] word);
        mem.words[cur_pc[11:2]] = word; // no fetch expectation recorded here.
        cur_pc += 4;
    endtask

    task automatic emit(input logic [31:0] word);
        exp_f[f_cnt] = cur_pc;
        f_cnt++;
        place(word);
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [3:0] m,
                                input logic [31:0] d);
        exp_wa[w_cnt] = addr;
        exp_wm[w_cnt] = m;
        exp_wd[w_cnt] = d;
        w_cnt++;
    endtask

    task automatic load_const(input int rd, input logic [31:0] v);
        logic [31:0] up;
        up = v + 32'h800; // addi sign-extends its low part.
        emit(enc_u(up[31:12], rd, 7'h37));
        emit(enc_i(v[11:0], rd, 0, rd, 7'h13));
    endtask

    task automatic store_word(input int rs2, input int off, input logic [31:0] d);
        emit(enc_s(off[11:0], rs2, 3, 2));
        expect_write(DATA_BASE + off, 4'hf, d);
    endtask

    task automatic start_program(input string name);
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk); // the previous program is checked up to this edge.
        test_name = name;
        f_cnt = 0;
        w_cnt = 0;
        r_cnt = 0;
        cur_pc = `RESET_PC;
        load_const(3, DATA_BASE); // x3 holds the data base.
    endtask

    task automatic run_program();
        logic [31:0] prev;
        bit          done;
        int          errors_before;
        errors_before = errors;
        emit(enc_j(21'd0, 0));
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        prev = 32'hffff_ffff;
        done = 0;
        for (int i = 0; i < 1000 && !done; i++) begin
            @(negedge clk);
            if (mem_1_addr == prev) done = 1;
            prev = mem_1_addr;
        end
        if (!done) begin
            $display("%s: timed out waiting for the fetch address to settle", test_name);
            errors++;
        end
        if (w_idx != w_cnt) begin
            $display("%s: saw %0d of %0d data writes", test_name, w_idx, w_cnt);
            errors++;
        end
        if (r_idx != r_cnt) begin
            $display("%s: saw %0d of %0d data reads", test_name, r_idx, r_cnt);
            errors++;
        end
        if (errors == errors_before) begin
            $display("test %s passed", test_name);
            passed++;
        end else begin
            $display("test %s failed", test_name);
            failed++;
        end
    endtask

    task automatic test_alu();
        logic [31:0] a, b;
        logic [11:0] imm;
        bit          alt;
        start_program("alu");
        a = lcg_next();
        b = lcg_next();
        load_const(1, a);
        load_const(2, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            for (int k = 0; k < 2; k++) begin
                if (k == 0 || f3 == 0 || f3 == 5) begin
                    emit(enc_r(k ? 7'h20 : 7'h00, 2, 1, f3, 4));
                    store_word(4, 0, alu_model(f3, k, a, b));
                end
            end
        end
        for (int f3 = 0; f3 < 8; f3++) begin
            imm = lcg_next() >> 7;
            alt = 0;
            if (f3 == 1 || f3 == 5) begin
                alt = (f3 == 5) && imm[11];
                imm = {alt ? 7'h20 : 7'h00, imm[4:0]};
            end
            emit(enc_i(imm, 1, f3, 4, 7'h13));
            store_word(4, 0, alu_model(f3, alt, a, {{20{imm[11]}}, imm}));
        end
        run_program();
    endtask

    task automatic test_store_lanes();
        logic [31:0] a;
        start_program("store_lanes");
        a = lcg_next();
        load_const(1, a);
        for (int off = 0; off < 4; off++) begin
            emit(enc_s(off[11:0], 1, 3, 0));
            expect_write(DATA_BASE, 4'b0001 << off, a << (8 * off));
        end
        for (int off = 0; off < 4; off += 2) begin
            emit(enc_s(off[11:0], 1, 3, 1));
            expect_write(DATA_BASE, 4'b0011 << off, a << (8 * off));
        end
        run_program();
    endtask

    task automatic test_loads();
        logic [31:0] a;
        int          kinds [5] = '{0, 4, 1, 5, 2};
        int          size;
        start_program("load_extend");
        a = lcg_next();
        load_const(1, a);
        store_word(1, 0, a);
        foreach (kinds[k]) begin
            size = 1 << kinds[k][1:0];
            for (int off = 0; off < 4; off += size) begin
                emit(enc_i(off[11:0], 3, kinds[k], 4, 7'h03));
                r_cnt++;
                store_word(4, 4, load_model(kinds[k], a, off));
            end
        end
        run_program();
    endtask

    task automatic test_control();
        logic [31:0] v [3];
        logic [31:0] p, link;
        logic [19:0] up;
        int          brs [6] = '{0, 1, 4, 5, 6, 7};
        int          r1 [3] = '{1, 2, 1};
        int          r2 [3] = '{2, 1, 1};
        start_program("control_flow");
        v[1] = lcg_next();
        v[2] = lcg_next();
        if (v[1] == v[2]) v[2] = ~v[1];
        load_const(1, v[1]);
        load_const(2, v[2]);
        foreach (brs[i]) begin
            for (int k = 0; k < 3; k++) begin
                emit(enc_b(13'd8, r2[k], r1[k], brs[i]));
                if (branch_model(brs[i], v[r1[k]], v[r2[k]])) place(`NOP_INST);
                else emit(`NOP_INST);
            end
        end
        link = cur_pc + 4;
        emit(enc_j(21'd8, 5));
        place(`NOP_INST);
        store_word(5, 0, link);
        p = cur_pc;
        load_const(6, p + 15); // odd base, bit 0 of the target is cleared.
        emit(enc_i(12'd2, 6, 0, 7, 7'h67));
        place(`NOP_INST);
        store_word(7, 0, p + 12);
        up = lcg_next() >> 12;
        link = cur_pc + {up, 12'b0};
        emit(enc_u(up, 8, 7'h17));
        store_word(8, 0, link);
        run_program();
    endtask

    initial begin
        test_alu();
        test_store_lanes();
        test_loads();
        test_control();
        $display("passed %0d, failed %0d", passed, failed);
        if (failed == 0 && errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
+incdir+rtl
rtl/core_pkg.sv
rtl/core_ifu.sv
rtl/core_idu.sv
rtl/core_ctrl.sv
rtl/core_exu.sv
rtl/core_memwb.sv
rtl/core.sv
tb/core_tb_mem.sv
tb/core_tb.sv
